// ==== logic/bus_pkg.sv ====
/*
 * Host register bus definitions.
 * Address map, address field helpers and the two views of the write word.
 */

package bus_pkg;

    typedef logic [15:0] addr_t;         // host register address

    // address fields ------------------
    localparam int FIELD_W   = 4;
    localparam int SPACE_LSB = 12;        // space in 15:12
    localparam int CHAN_LSB  = 4;         // channel in 7:4
    localparam int OFF_LSB   = 0;         // offset in 3:0

    localparam logic [3:0] ADDR_MAIN    = 4'h0;
    localparam logic [3:0] OFF_ADC_DATA = 4'd0;
    localparam logic [3:0] OFF_DAC_CTRL = 4'd1;
    localparam logic [3:0] OFF_STATUS   = 4'd0;   // channel 0 only

    // status read word bit positions
    localparam int ST_BOARD_ID_LSB = 24;
    localparam int ST_DISABLE_LSB  = 16;
    localparam int ST_PWR_BIT      = 8;
    localparam int ST_AMP_LSB      = 0;

    // write word, decoded as a current command or as a status write
    typedef union packed {
        struct packed {
            logic [15:0] rsvd;
            logic [15:0] current;
        } cmd;
        struct packed {
            logic [22:0] ign_hi;
            logic        pwr_enable;      // bit 8
            logic [3:0]  ign_lo;
            logic [3:0]  amp_enable;      // per-axis request
        } status;
    } reg_word_u;

    function automatic logic [3:0] addr_space(input addr_t a);
        return a[SPACE_LSB +: FIELD_W];
    endfunction

    function automatic logic [3:0] addr_chan(input addr_t a);
        return a[CHAN_LSB +: FIELD_W];
    endfunction

    function automatic logic [3:0] addr_off(input addr_t a);
        return a[OFF_LSB +: FIELD_W];
    endfunction

endpackage

// ==== logic/motor_pkg.sv ====
/*
 * Motor current path constants.
 * Axis count, current word format and the quad DAC frame layout.
 */

package motor_pkg;

    localparam int NUM_CHANNELS = 4;

    // offset binary, midscale is zero current
    typedef logic [15:0] cur_t;

    localparam cur_t CUR_MID = 16'h8000;

    // quad DAC frame ------------------
    // cmd(4) | channel(4) | data(16), msb first
    localparam int         DAC_FRAME_BITS = 24;
    localparam logic [3:0] DAC_CMD        = 4'd3;   // write and update

endpackage

// ==== logic/cur_cmd_regs.sv ====
/*
 * Commanded-current registers for axes 1 to 4.
 * A block write to the DAC offset requests a DAC update, which is held
 * while the serializer is busy and merged with later requests.
 */

`timescale 1ns/100ps

module cur_cmd_regs (
    input  logic           sysclk,
    input  logic           rst_n,
    input  logic           reg_wen,
    input  logic           blk_wen,
    input  bus_pkg::addr_t reg_waddr,
    input  logic [31:0]    reg_wdata,
    input  logic           dac_busy,
    output motor_pkg::cur_t [motor_pkg::NUM_CHANNELS-1:0] cur_cmd,
    output logic           dac_start
);
    import bus_pkg::*;
    import motor_pkg::*;

    reg_word_u  wr_word;
    logic [3:0] wr_chan;
    logic       dac_wr;       // write to an axis DAC offset
    logic       upd_req;      // pending DAC update
    logic       upd_go;

    assign wr_word = reg_wdata;
    assign wr_chan = addr_chan(reg_waddr);

    // channel 0 and channels above 4 are not axes
    assign dac_wr = reg_wen && (addr_space(reg_waddr) == ADDR_MAIN)
                 && (addr_off(reg_waddr) == OFF_DAC_CTRL)
                 && (wr_chan != 4'd0) && (wr_chan <= NUM_CHANNELS);

    // dac_start still high means busy has not risen yet
    assign upd_go = upd_req && !dac_busy && !dac_start;

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            cur_cmd   <= {NUM_CHANNELS{CUR_MID}};
            upd_req   <= 1'b0;
            dac_start <= 1'b0;
        end else begin
            if (dac_wr)
                cur_cmd[wr_chan - 4'd1] <= wr_word.cmd.current;

            if (dac_wr && blk_wen)
                upd_req <= 1'b1;            // merges with a held request
            else if (upd_go)
                upd_req <= 1'b0;

            dac_start <= upd_go;            // one-cycle strobe
        end
    end

endmodule

// ==== logic/dac_serializer.sv ====
/*
 * Serial quad DAC shifter.
 * Snapshots all four commands on dac_start, then sends one 24-bit frame
 * per channel, msb first, with chip select high between frames.
 */

`timescale 1ns/100ps

module dac_serializer #(
    parameter int DAC_SCLK_DIV = 2          // sysclk cycles per sclk half period
) (
    input  logic  sysclk,
    input  logic  rst_n,
    input  logic  dac_start,
    input  motor_pkg::cur_t [motor_pkg::NUM_CHANNELS-1:0] cur_cmd,
    output logic  dac_busy,
    output logic  dac_sclk,
    output logic  dac_mosi,
    output logic  dac_csel
);
    import motor_pkg::*;

    localparam int DIV_W = (DAC_SCLK_DIV > 1) ? $clog2(DAC_SCLK_DIV) : 1;
    localparam int BIT_W = $clog2(DAC_FRAME_BITS);
    localparam int FR_W  = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1;

    localparam logic [DIV_W-1:0] DIV_LAST   = DIV_W'(DAC_SCLK_DIV - 1);
    localparam logic [BIT_W-1:0] BIT_LAST   = BIT_W'(DAC_FRAME_BITS - 1);
    localparam logic [FR_W-1:0]  FRAME_LAST = FR_W'(NUM_CHANNELS - 1);

    cur_t [NUM_CHANNELS-1:0]   snap;        // commands for this update
    logic [DAC_FRAME_BITS-1:0] shift;
    logic [DIV_W-1:0]          div_cnt;
    logic [BIT_W-1:0]          bit_cnt;
    logic [FR_W-1:0]           frame;
    logic [FR_W-1:0]           nxt_frame;
    logic                      gap;         // second half of the csel-high gap
    logic                      tick;

    function automatic logic [DAC_FRAME_BITS-1:0] frame_word(input logic [3:0] idx,
                                                             input cur_t val);
        return {DAC_CMD, idx, val};
    endfunction

    assign tick      = (div_cnt == DIV_LAST);
    assign nxt_frame = frame + 1'b1;
    assign dac_mosi  = !dac_csel && shift[DAC_FRAME_BITS-1];   // quiet when deselected

    // ------------------------------
    // divider, bit and frame sequencing
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            dac_busy <= 1'b0;
            dac_csel <= 1'b1;
            dac_sclk <= 1'b0;
            div_cnt  <= '0;
            bit_cnt  <= '0;
            frame    <= '0;
            gap      <= 1'b0;
        end else if (!dac_busy) begin
            div_cnt <= '0;
            if (dac_start) begin
                dac_busy <= 1'b1;
                dac_csel <= 1'b0;           // first frame opens right away
                bit_cnt  <= '0;
                frame    <= '0;
            end
        end else begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
            if (tick && !dac_csel) begin
                dac_sclk <= !dac_sclk;
                if (dac_sclk) begin         // falling edge
                    if (bit_cnt == BIT_LAST) begin
                        dac_csel <= 1'b1;
                        gap      <= 1'b0;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
            end else if (tick) begin
                gap <= !gap;                // one full sclk period high
                if (gap) begin
                    if (frame == FRAME_LAST) begin
                        dac_busy <= 1'b0;
                    end else begin
                        frame    <= nxt_frame;
                        bit_cnt  <= '0;
                        dac_csel <= 1'b0;
                    end
                end
            end
        end
    end

    // ------------------------------
    // frame data
    always_ff @(posedge sysclk) begin
        if (!dac_busy && dac_start) begin
            snap  <= cur_cmd;
            shift <= frame_word(4'd0, cur_cmd[0]);
        end else if (dac_busy && tick) begin
            if (!dac_csel && dac_sclk && bit_cnt != BIT_LAST)
                shift <= shift << 1;        // next bit while sclk goes low
            else if (dac_csel && gap && frame != FRAME_LAST)
                shift <= frame_word(4'(nxt_frame), snap[nxt_frame]);
        end
    end

endmodule

// ==== logic/safety_check.sv ====
/*
 * Per-axis overcurrent check.
 * Counts consecutive feedback samples above twice the command plus a
 * margin and latches an amplifier disable until it is cleared.
 */

`timescale 1ns/100ps

module safety_check #(
    parameter int              SAFETY_COUNT  = 8,         // bad samples to trip
    parameter motor_pkg::cur_t SAFETY_MARGIN = 16'h0100   // allowed excess
) (
    input  logic            sysclk,
    input  logic            rst_n,
    input  logic            cur_fb_wen,
    input  motor_pkg::cur_t cur_fb,
    input  motor_pkg::cur_t cur_cmd,
    input  logic            clear_disable,
    output logic            amp_disable
);
    import motor_pkg::*;

    localparam int CNT_W = $clog2(SAFETY_COUNT + 1);
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(SAFETY_COUNT);

    logic [15:0]      fb_mag;
    logic [15:0]      cmd_mag;
    logic [17:0]      limit;        // 2*cmd + margin, no overflow
    logic             over;
    logic             smp_vld;      // registered strobe
    logic             smp_bad;
    logic [CNT_W-1:0] viol_cnt;

    // distance from midscale
    function automatic logic [15:0] mag(input cur_t v);
        return v[15] ? (v - CUR_MID) : (CUR_MID - v);
    endfunction

    assign fb_mag  = mag(cur_fb);
    assign cmd_mag = mag(cur_cmd);
    assign limit   = {1'b0, cmd_mag, 1'b0} + 18'(SAFETY_MARGIN);
    assign over    = 18'(fb_mag) > limit;

    always_ff @(posedge sysclk)
        smp_bad <= over;

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            smp_vld     <= 1'b0;
            viol_cnt    <= '0;
            amp_disable <= 1'b0;
        end else begin
            smp_vld <= cur_fb_wen;
            if (clear_disable) begin
                amp_disable <= 1'b0;
                viol_cnt    <= '0;
            end else if (smp_vld) begin
                if (!smp_bad) begin
                    viol_cnt <= '0;             // good sample breaks the run
                end else if (viol_cnt != CNT_MAX) begin
                    viol_cnt <= viol_cnt + 1'b1;
                    if (viol_cnt == CNT_MAX - 1'b1)
                        amp_disable <= 1'b1;    // trips as count reaches max
                end
            end
        end
    end

endmodule

// ==== logic/board_status_regs.sv ====
/*
 * Board status register, channel 0.
 * Holds power and amplifier enables, clears safety disables on enable
 * writes and builds the status read word.
 */

`timescale 1ns/100ps

module board_status_regs (
    input  logic           sysclk,
    input  logic           rst_n,
    input  logic [3:0]     wenid,
    input  logic           reg_wen,
    input  bus_pkg::addr_t reg_waddr,
    input  logic [31:0]    reg_wdata,
    input  logic [motor_pkg::NUM_CHANNELS-1:0] amp_disable,
    output logic [motor_pkg::NUM_CHANNELS-1:0] clear_disable,
    output logic           pwr_enable,
    output logic [motor_pkg::NUM_CHANNELS-1:0] amp_enable,
    output logic [31:0]    status_word
);
    import bus_pkg::*;
    import motor_pkg::*;

    reg_word_u               wr_word;
    logic                    st_wr;
    logic [NUM_CHANNELS-1:0] amp_req;     // requested enables

    assign wr_word = reg_wdata;
    assign st_wr   = reg_wen && (addr_space(reg_waddr) == ADDR_MAIN)
                  && (addr_chan(reg_waddr) == 4'd0)
                  && (addr_off(reg_waddr) == OFF_STATUS);

    // enabling an axis, or power, re-arms its safety check
    assign clear_disable = st_wr ? (wr_word.status.amp_enable
                                    | {NUM_CHANNELS{wr_word.status.pwr_enable}})
                                 : '0;

    assign amp_enable = amp_req & ~amp_disable;    // tripped axes masked off

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            pwr_enable <= 1'b0;
            amp_req    <= '0;
        end else if (st_wr) begin
            pwr_enable <= wr_word.status.pwr_enable;
            amp_req    <= wr_word.status.amp_enable;
        end
    end

    // ------------------------------
    // status read layout
    always_comb begin
        status_word = '0;
        status_word[ST_BOARD_ID_LSB +: 4]           = ~wenid;  // switch is inverted
        status_word[ST_DISABLE_LSB +: NUM_CHANNELS] = amp_disable;
        status_word[ST_PWR_BIT]                     = pwr_enable;
        status_word[ST_AMP_LSB +: NUM_CHANNELS]     = amp_enable;
    end

endmodule

// ==== logic/reg_read_mux.sv ====
/*
 * Host read path.
 * Latches the converted feedback and selects status, feedback or
 * command data by address; unmapped reads give zero.
 */

`timescale 1ns/100ps

module reg_read_mux (
    input  logic           sysclk,
    input  logic           rst_n,
    input  logic           cur_fb_wen,
    input  motor_pkg::cur_t [motor_pkg::NUM_CHANNELS-1:0] cur_fb,
    input  motor_pkg::cur_t [motor_pkg::NUM_CHANNELS-1:0] cur_cmd,
    input  logic [31:0]    status_word,
    input  bus_pkg::addr_t reg_raddr,
    output logic [31:0]    reg_rdata
);
    import bus_pkg::*;
    import motor_pkg::*;

    cur_t [NUM_CHANNELS-1:0] fb_q;     // last converted feedback
    logic [3:0]              rd_chan;
    logic [3:0]              rd_off;

    assign rd_chan = addr_chan(reg_raddr);
    assign rd_off  = addr_off(reg_raddr);

    always_ff @(posedge sysclk) begin
        if (!rst_n)
            fb_q <= {NUM_CHANNELS{CUR_MID}};
        else if (cur_fb_wen)
            fb_q <= cur_fb;
    end

    always_comb begin
        reg_rdata = '0;
        if (addr_space(reg_raddr) == ADDR_MAIN) begin
            if (rd_chan == 4'd0) begin
                if (rd_off == OFF_STATUS)
                    reg_rdata = status_word;
            end else if (rd_chan <= NUM_CHANNELS) begin
                if (rd_off == OFF_ADC_DATA)
                    reg_rdata = {16'h0, fb_q[rd_chan - 4'd1]};
                else if (rd_off == OFF_DAC_CTRL)
                    reg_rdata = {16'h0, cur_cmd[rd_chan - 4'd1]};
            end
        end
    end

endmodule

// ==== logic/motor_ctrl_top.sv ====
/*
 * Motor controller current path, top level.
 * Command registers, quad DAC serializer, per-axis safety checks,
 * board status register and the host read mux.
 */

`timescale 1ns/100ps

module motor_ctrl_top #(
    parameter int              SAFETY_COUNT  = 8,
    parameter motor_pkg::cur_t SAFETY_MARGIN = 16'h0100,
    parameter int              DAC_SCLK_DIV  = 2
) (
    input  logic                   sysclk,
    input  logic                   rst_n,
    input  logic [3:0]             wenid,       // rotary switch
    input  logic                   reg_wen,
    input  logic                   blk_wen,
    input  bus_pkg::addr_t         reg_waddr,
    input  logic [31:0]            reg_wdata,
    input  bus_pkg::addr_t         reg_raddr,
    output logic [31:0]            reg_rdata,
    input  logic                   cur_fb_wen,  // converted feedback strobe
    input  motor_pkg::cur_t [motor_pkg::NUM_CHANNELS-1:0] cur_fb,
    output logic                   dac_sclk,
    output logic                   dac_mosi,
    output logic                   dac_csel,
    output logic                   pwr_enable,
    output logic [3:0]             amp_enable
);
    import motor_pkg::*;

    cur_t [NUM_CHANNELS-1:0] cur_cmd;
    logic                    dac_start;
    logic                    dac_busy;
    logic [NUM_CHANNELS-1:0] amp_disable;
    logic [NUM_CHANNELS-1:0] clear_disable;
    logic [31:0]             status_word;

    // ------------------------------
    // command path to the DAC
    cur_cmd_regs cmd_regs (
        .sysclk(sysclk), .rst_n(rst_n),
        .reg_wen(reg_wen), .blk_wen(blk_wen),
        .reg_waddr(reg_waddr), .reg_wdata(reg_wdata),
        .dac_busy(dac_busy), .cur_cmd(cur_cmd), .dac_start(dac_start)
    );

    dac_serializer #(.DAC_SCLK_DIV(DAC_SCLK_DIV)) dac (
        .sysclk(sysclk), .rst_n(rst_n),
        .dac_start(dac_start), .cur_cmd(cur_cmd), .dac_busy(dac_busy),
        .dac_sclk(dac_sclk), .dac_mosi(dac_mosi), .dac_csel(dac_csel)
    );

    // ------------------------------
    // safety, one checker per axis
    for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_safe
        safety_check #(
            .SAFETY_COUNT(SAFETY_COUNT),
            .SAFETY_MARGIN(SAFETY_MARGIN)
        ) safe (
            .sysclk(sysclk), .rst_n(rst_n),
            .cur_fb_wen(cur_fb_wen), .cur_fb(cur_fb[i]), .cur_cmd(cur_cmd[i]),
            .clear_disable(clear_disable[i]), .amp_disable(amp_disable[i])
        );
    end

    board_status_regs chan0 (
        .sysclk(sysclk), .rst_n(rst_n), .wenid(wenid),
        .reg_wen(reg_wen), .reg_waddr(reg_waddr), .reg_wdata(reg_wdata),
        .amp_disable(amp_disable), .clear_disable(clear_disable),
        .pwr_enable(pwr_enable), .amp_enable(amp_enable),
        .status_word(status_word)
    );

    // ------------------------------
    reg_read_mux rd_mux (
        .sysclk(sysclk), .rst_n(rst_n),
        .cur_fb_wen(cur_fb_wen), .cur_fb(cur_fb), .cur_cmd(cur_cmd),
        .status_word(status_word), .reg_raddr(reg_raddr), .reg_rdata(reg_rdata)
    );

endmodule

// ==== include/tb_tasks.svh ====
/*
 * Bus, feedback and DAC frame tasks for the motor current testbench.
 */

`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

function automatic logic [15:0] main_addr(input logic [3:0] chan, input logic [3:0] off);
    return {4'h0, 4'h0, chan, off};     // main space
endfunction

// one-cycle write strobe
task automatic write_reg(input logic [15:0] addr, input logic [31:0] data, input logic blk);
    @(negedge sysclk);
    reg_waddr = addr;
    reg_wdata = data;
    blk_wen   = blk;
    reg_wen   = 1'b1;
    @(negedge sysclk);
    reg_wen   = 1'b0;
    blk_wen   = 1'b0;
endtask

task automatic read_expect(input logic [15:0] addr, input logic [31:0] exp, input string name);
    @(negedge sysclk);
    reg_raddr = addr;
    #(CLK_PERIOD / 4);                  // comb read settles
    check_equal(name, exp, reg_rdata);
endtask

task automatic drive_feedback(input logic [15:0] fb [4]);
    @(negedge sysclk);
    for (int i = 0; i < 4; i++)
        cur_fb[i] = fb[i];
    cur_fb_wen = 1'b1;
    @(negedge sysclk);
    cur_fb_wen = 1'b0;
endtask

// ------------------------------
// DAC side
task automatic wait_csel_low(input int limit);
    int n;
    n = 0;
    while (dac_csel !== 1'b0) begin
        @(negedge sysclk);
        n++;
        if (n > limit)
            abort_run("timed out waiting for dac_csel to go low");
    end
endtask

task automatic capture_frame(output logic [23:0] word, output int nbits);
    logic prev_sclk;
    int   waited;
    word      = '0;
    nbits     = 0;
    waited    = 0;
    prev_sclk = dac_sclk;
    while (dac_csel === 1'b0) begin
        @(negedge sysclk);
        if (dac_sclk && !prev_sclk && !dac_csel) begin
            word = {word[22:0], dac_mosi};   // msb first
            nbits++;
        end
        prev_sclk = dac_sclk;
        waited++;
        if (waited > FRAME_TIMEOUT)
            abort_run("DAC frame did not end within the timeout");
    end
endtask

// four frames, channel 0 to 3
task automatic check_dac_update(input logic [15:0] cmd [4]);
    logic [23:0] word;
    int          nbits;
    for (int k = 0; k < 4; k++) begin
        wait_csel_low(k == 0 ? START_TIMEOUT : FRAME_TIMEOUT);
        capture_frame(word, nbits);
        check_equal($sformatf("dac frame %0d length", k), 32'(FRAME_BITS), 32'(nbits));
        check_equal($sformatf("dac_mosi frame %0d", k),
                    {8'h0, DAC_CMD, 4'(k), cmd[k]}, {8'h0, word});
    end
endtask

task automatic expect_dac_idle(input int cycles);
    for (int n = 0; n < cycles; n++) begin
        @(negedge sysclk);
        assert (dac_csel === 1'b1)
            else abort_run("a DAC update started without a pending block write");
    end
endtask

`endif

// ==== bench/tb_motor_ctrl.sv ====
/*
 * Testbench for the motor current path.
 * Drives the host bus and converted feedback, decodes the quad DAC
 * frames and checks readback, status and safety trips with assertions.
 */

`timescale 1ns/100ps

module tb_motor_ctrl;

    localparam int          CLK_PERIOD    = 8;
    localparam int          SAFETY_COUNT  = 8;          // dut defaults
    localparam logic [15:0] SAFETY_MARGIN = 16'h0100;
    localparam int          DAC_SCLK_DIV  = 2;
    localparam logic [15:0] CUR_MID       = 16'h8000;
    localparam int          FRAME_BITS    = 24;
    localparam logic [3:0]  DAC_CMD       = 4'd3;       // write and update
    localparam logic [3:0]  OFF_ADC_DATA  = 4'd0;
    localparam logic [3:0]  OFF_DAC_CTRL  = 4'd1;
    localparam logic [3:0]  OFF_STATUS    = 4'd0;
    localparam int          START_TIMEOUT = 64;         // cycles until csel drops
    localparam int          FRAME_TIMEOUT = 4 * DAC_SCLK_DIV * FRAME_BITS;

    logic             sysclk;
    logic             rst_n;
    logic [3:0]       wenid;
    logic             reg_wen;
    logic             blk_wen;
    logic [15:0]      reg_waddr;
    logic [31:0]      reg_wdata;
    logic [15:0]      reg_raddr;
    logic [31:0]      reg_rdata;
    logic             cur_fb_wen;
    logic [3:0][15:0] cur_fb;
    logic             dac_sclk;
    logic             dac_mosi;
    logic             dac_csel;
    logic             pwr_enable;
    logic [3:0]       amp_enable;

    integer seed = 32'h55;

    // reference model state
    logic [15:0] exp_cmd [4];
    logic [15:0] old_cmd [4];
    logic [15:0] last_fb [4];
    int          run_len [4];      // consecutive bad samples per axis
    logic [3:0]  exp_dis;
    logic        exp_pwr;
    logic [3:0]  exp_amp_req;

    motor_ctrl_top dut0 (
        .sysclk(sysclk), .rst_n(rst_n), .wenid(wenid),
        .reg_wen(reg_wen), .blk_wen(blk_wen), .reg_waddr(reg_waddr),
        .reg_wdata(reg_wdata), .reg_raddr(reg_raddr), .reg_rdata(reg_rdata),
        .cur_fb_wen(cur_fb_wen), .cur_fb(cur_fb),
        .dac_sclk(dac_sclk), .dac_mosi(dac_mosi), .dac_csel(dac_csel),
        .pwr_enable(pwr_enable), .amp_enable(amp_enable)
    );

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_equal(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp)
            else abort_run($sformatf("FAIL t=%0t %s exp=%h act=%h", $time, name, exp, act));
    endtask

    `include "tb_tasks.svh"

    // ------------------------------
    // model of the status word and the safety rule
    function automatic logic [31:0] expected_status();
        return {4'h0, ~wenid, 4'h0, exp_dis, 7'h0, exp_pwr, 4'h0, exp_amp_req & ~exp_dis};
    endfunction

    function automatic logic [15:0] cur_mag(input logic [15:0] v);
        return (v >= CUR_MID) ? v - CUR_MID : CUR_MID - v;
    endfunction

    function automatic logic is_violation(input logic [15:0] fb, input logic [15:0] cmd);
        return {2'b0, cur_mag(fb)} > ({2'b0, cur_mag(cmd)} << 1) + 18'(SAFETY_MARGIN);
    endfunction

    task automatic write_cmd(input int idx, input logic [15:0] val, input logic blk);
        exp_cmd[idx] = val;
        write_reg(main_addr(4'(idx + 1), OFF_DAC_CTRL), {16'($random(seed)), val}, blk);
    endtask

    task automatic write_status(input logic pwr, input logic [3:0] amp);
        logic [3:0] clr;
        clr         = amp | {4{pwr}};   // enable writes re-arm the checks
        exp_pwr     = pwr;
        exp_amp_req = amp;
        exp_dis     = exp_dis & ~clr;
        for (int i = 0; i < 4; i++)
            if (clr[i]) run_len[i] = 0;
        write_reg(main_addr(4'd0, OFF_STATUS),
                  {23'($random(seed)), pwr, 4'($random(seed)), amp}, 1'b0);
    endtask

    task automatic check_status();
        read_expect(main_addr(4'd0, OFF_STATUS), expected_status(), "status word");
        check_equal("pwr_enable", 32'(exp_pwr), 32'(pwr_enable));
        check_equal("amp_enable", 32'(exp_amp_req & ~exp_dis), 32'(amp_enable));
    endtask

    task automatic check_axis_regs();
        for (int i = 0; i < 4; i++) begin
            read_expect(main_addr(4'(i + 1), OFF_DAC_CTRL), {16'h0, exp_cmd[i]},
                        $sformatf("cmd axis %0d", i));
            read_expect(main_addr(4'(i + 1), OFF_ADC_DATA), {16'h0, last_fb[i]},
                        $sformatf("feedback axis %0d", i));
        end
    endtask

    // one sample on all axes with bad_mask choosing the overcurrent ones
    task automatic send_sample(input logic [3:0] bad_mask);
        logic [15:0] fb [4];
        for (int i = 0; i < 4; i++) begin
            fb[i] = bad_mask[i] ? CUR_MID - 16'h0300 - 16'($random(seed) & 32'hff)
                                : exp_cmd[i];
            run_len[i] = is_violation(fb[i], exp_cmd[i]) ? run_len[i] + 1 : 0;
            if (run_len[i] >= SAFETY_COUNT)
                exp_dis[i] = 1'b1;
            last_fb[i] = fb[i];
        end
        drive_feedback(fb);
    endtask

    // ------------------------------
    initial begin
        sysclk = 1'b0;
        forever #(CLK_PERIOD / 2) sysclk = ~sysclk;
    end

    // spi mode 0 on the DAC pins
    assert property (@(posedge sysclk) disable iff (!rst_n) dac_csel |-> !dac_sclk)
        else abort_run("dac_sclk was high while dac_csel was deasserted");
    assert property (@(posedge sysclk) disable iff (!rst_n) !$stable(dac_mosi) |-> !dac_sclk)
        else abort_run("dac_mosi changed while dac_sclk was high");

    initial begin
        rst_n       = 1'b0;
        wenid       = 4'hA;
        reg_wen     = 1'b0;
        blk_wen     = 1'b0;
        reg_waddr   = '0;
        reg_wdata   = '0;
        reg_raddr   = '0;
        cur_fb_wen  = 1'b0;
        cur_fb      = {4{CUR_MID}};
        exp_dis     = '0;
        exp_pwr     = 1'b0;
        exp_amp_req = '0;
        for (int i = 0; i < 4; i++) begin
            exp_cmd[i] = CUR_MID;
            last_fb[i] = CUR_MID;
            run_len[i] = 0;
        end
        repeat (16) @(negedge sysclk);
        rst_n = 1'b1;

        // reset state
        check_equal("dac_csel", 32'd1, 32'(dac_csel));
        check_equal("dac_sclk", 32'd0, 32'(dac_sclk));
        check_status();
        check_axis_regs();

        // ------------------------------
        // command readback, ignored channels, other space, no update
        for (int i = 0; i < 4; i++) begin
            write_cmd(i, 16'($random(seed)), 1'b0);
            read_expect(main_addr(4'(i + 1), OFF_DAC_CTRL), {16'h0, exp_cmd[i]}, "cmd readback");
        end
        write_reg(main_addr(4'd0, OFF_DAC_CTRL), $random(seed), 1'b0);
        write_reg(main_addr(4'd5, OFF_DAC_CTRL), $random(seed), 1'b0);
        check_axis_regs();
        read_expect(16'h1011, 32'h0, "reg_rdata other space");
        expect_dac_idle(FRAME_TIMEOUT);

        // ------------------------------
        // block write, then two more while busy merge into one update
        for (int i = 0; i < 3; i++)
            write_cmd(i, 16'($random(seed)), 1'b0);
        write_cmd(3, 16'($random(seed)), 1'b1);
        old_cmd = exp_cmd;
        fork
            check_dac_update(old_cmd);
            begin
                wait_csel_low(START_TIMEOUT);
                for (int i = 0; i < 3; i++)
                    write_cmd(i, 16'($random(seed)), i > 0);
            end
        join
        check_dac_update(exp_cmd);
        expect_dac_idle(FRAME_TIMEOUT);
        check_axis_regs();

        // ------------------------------
        // enables, then a near miss and a trip on axis 2
        write_status(1'b1, 4'hF);
        check_status();
        for (int i = 0; i < 4; i++)
            write_cmd(i, CUR_MID + 16'h0040, 1'b0);
        repeat (SAFETY_COUNT - 1) send_sample(4'b0100);
        send_sample(4'b0000);
        check_status();
        repeat (SAFETY_COUNT - 1) send_sample(4'b0100);
        check_status();                   // good sample restarted the count
        send_sample(4'b0100);
        check_status();
        check_axis_regs();
        write_status(1'b0, 4'b0100);      // re-enable the tripped axis only
        check_status();

        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== motor_ctrl_top.f ====
+incdir+include
logic/bus_pkg.sv
logic/motor_pkg.sv
logic/cur_cmd_regs.sv
logic/dac_serializer.sv
logic/safety_check.sv
logic/board_status_regs.sv
logic/reg_read_mux.sv
logic/motor_ctrl_top.sv
bench/tb_motor_ctrl.sv
